// File: src/z80_bus_pkg.sv
`default_nettype none

package z80_bus_pkg;

   // ********************
   // Bus cycle kinds
   // ********************
   typedef enum logic [2:0] {
      cyc_none,                                 // Idle or unsupported cycle
      cyc_mem_read,                             // MREQ with RD
      cyc_mem_write,                            // MREQ with WR
      cyc_port_read,                            // IORQ with RD
      cyc_port_write                            // IORQ with WR
   } z80_cycle_e;

   // ********************
   // Widths and filter setup
   // ********************
   localparam int ADDR_W      = 22;             // uCom extended address bus
   localparam int DATA_W      = 8;              // Z80 data bus
   localparam int GPU_ADDR_W  = 20;             // GPU RAM address
   localparam bit USE_Z80_CLK = 1'b1;           // Step filters only on Z80 clock edges
   localparam bit INV_Z80_CLK = 1'b0;           // Swap rising and falling edge sense
   localparam int MEM_FILTER  = 0;              // Extra Z80 edges before memory cycle counts
   localparam int PORT_FILTER = 2;              // Extra Z80 edges before port cycle counts
   localparam int FILTER_W    = 3;              // Filter counter width

   // Level converter direction
   localparam logic DIR_IN  = 1'b0;             // Toward FPGA
   localparam logic DIR_OUT = 1'b1;             // Toward Z80

endpackage

`default_nettype wire

// File: src/gpu_map_pkg.sv
`default_nettype none

package gpu_map_pkg;

   // ********************
   // Memory window
   // ********************
   localparam logic [2:0]  MEM_BANK       = 3'd2;   // addr[21:19], 512 KB window
   localparam logic [19:0] MEM_SIZE_BYTES = 20'd40960; // GPU RAM plus palette
   localparam bit          BANK_RESPONSE  = 1'b1;   // Answer bank ID queries
   localparam logic [14:0] BANK_ID_ADDR   = '1;     // Compared with addr[18:4]

   // Sixteen byte bank identity string
   localparam logic [7:0] BANK_ID [16] = '{
      8'd9,  8'd3,  8'd71, 8'd80, 8'd85, 8'd32, 8'd69,  8'd80,
      8'd52, 8'd67, 8'd69, 8'd49, 8'd48, 8'd0,  8'd255, 8'd255
   };

   // ********************
   // IO ports
   // ********************
   typedef enum logic [7:0] {
      io_data   = 8'd240,                       // Keyboard character
      io_stat   = 8'd241,                       // Keyboard status
      snd_out   = 8'd242,                       // Speaker enable
      snd_ton   = 8'd244,                       // Sound tone register
      snd_dur   = 8'd245,                       // Sound duration register
      geo_lo    = 8'd246,                       // Geometry unit low byte
      geo_hi    = 8'd247,                       // Geometry unit high byte
      fifo_stat = 8'd248                        // Geometry FIFO status
   } io_port_e;

   localparam logic [7:0] PORT_FIRST = 8'd240;  // Lowest answered port
   localparam logic [7:0] PORT_LAST  = 8'd248;  // Highest answered port

   // Four low samples then four high, oldest in bit 7
   localparam logic [7:0] PS2_RDY_PATTERN = 8'b0000_1111;

endpackage

`default_nettype wire

// File: src/z80_bus_sampler.sv
`timescale 1ns/1ps
`default_nettype none

module z80_bus_sampler (
   input  wire logic                              GPU_CLK,
   input  wire logic                              arst_n,
   input  wire logic                              z80_clk,
   input  wire logic                              m1_n,
   input  wire logic                              mreq_n,
   input  wire logic                              iorq_n,
   input  wire logic                              rd_n,
   input  wire logic                              wr_n,
   input  wire logic [z80_bus_pkg::ADDR_W-1:0]    z80_addr,
   input  wire logic [z80_bus_pkg::DATA_W-1:0]    z80_wdata,
   output logic      [z80_bus_pkg::ADDR_W-1:0]    addr_q,
   output logic      [z80_bus_pkg::DATA_W-1:0]    wdata_q,
   output logic                                   rd_n_q,
   output logic                                   wr_n_q,
   output logic                                   zclk,
   output logic                                   raw_mem_read,
   output logic                                   raw_mem_write,
   output logic                                   raw_port_read,
   output logic                                   raw_port_write
);

   logic                    m1_n_q, mreq_n_q, iorq_n_q; // Sampled control levels
   logic                    zclk_q, zclk_q2;            // Z80 clock history
   logic                    z_rise;
   z80_bus_pkg::z80_cycle_e cycle;

   // Control strobes idle high
   always_ff @(posedge GPU_CLK or negedge arst_n) begin
      if (!arst_n) begin
         {m1_n_q, mreq_n_q, iorq_n_q, rd_n_q, wr_n_q} <= '1;
         {zclk_q, zclk_q2} <= '0;
      end else begin
         {m1_n_q, mreq_n_q, iorq_n_q} <= {m1_n, mreq_n, iorq_n};
         {rd_n_q, wr_n_q} <= {rd_n, wr_n};
         zclk_q  <= z80_clk;                    // First stage also registers the pin
         zclk_q2 <= zclk_q;
      end
   end

   always_ff @(posedge GPU_CLK) begin
      addr_q  <= z80_addr;                      // Sampled address and write data
      wdata_q <= z80_wdata;
   end

   // Edge sense swaps when the Z80 clock is taken inverted
   assign z_rise = z80_bus_pkg::INV_Z80_CLK ? (~zclk_q & zclk_q2) : (zclk_q & ~zclk_q2);
   assign zclk   = z_rise | ~z80_bus_pkg::USE_Z80_CLK; // Free running when unused

   // ********************
   // Cycle decode
   // ********************
   always_comb begin
      cycle = z80_bus_pkg::cyc_none;           // Opcode fetch falls through here
      if (m1_n_q && !mreq_n_q && iorq_n_q) begin
         if (!rd_n_q && wr_n_q)      cycle = z80_bus_pkg::cyc_mem_read;
         else if (rd_n_q && !wr_n_q) cycle = z80_bus_pkg::cyc_mem_write;
      end else if (m1_n_q && mreq_n_q && !iorq_n_q) begin
         if (!rd_n_q && wr_n_q)      cycle = z80_bus_pkg::cyc_port_read;
         else if (rd_n_q && !wr_n_q) cycle = z80_bus_pkg::cyc_port_write;
      end
   end

   assign raw_mem_read   = (cycle == z80_bus_pkg::cyc_mem_read);
   assign raw_mem_write  = (cycle == z80_bus_pkg::cyc_mem_write);
   assign raw_port_read  = (cycle == z80_bus_pkg::cyc_port_read);
   assign raw_port_write = (cycle == z80_bus_pkg::cyc_port_write);

endmodule

`default_nettype wire

// File: src/z80_cycle_filter.sv
`timescale 1ns/1ps
`default_nettype none

module z80_cycle_filter #(
   parameter int unsigned FILTER_LEN = 0          // Qualifying zclk pulses before active
) (
   input  wire logic GPU_CLK,
   input  wire logic arst_n,
   input  wire logic zclk,
   input  wire logic raw,
   input  wire logic strobe_n,
   output logic      active,
   output logic      start
);

   localparam logic [z80_bus_pkg::FILTER_W-1:0] LEN = FILTER_LEN[z80_bus_pkg::FILTER_W-1:0];

   logic [z80_bus_pkg::FILTER_W-1:0] cnt;         // Hysteresis counter
   logic                             active_d;    // For the start one-shot

   always_ff @(posedge GPU_CLK or negedge arst_n) begin
      if (!arst_n) begin
         cnt      <= '0;
         active   <= 1'b0;
         active_d <= 1'b0;
      end else begin
         active_d <= active;
         if (strobe_n) begin                      // Strobe released ends the cycle
            cnt    <= '0;
            active <= 1'b0;
         end else if (zclk && raw) begin
            if (cnt != LEN) cnt <= cnt + 1'b1;    // Still settling
            else            active <= 1'b1;
         end
      end
   end

   assign start = active & ~active_d;             // First cycle of active

endmodule

`default_nettype wire

// File: src/z80_mem_port.sv
`timescale 1ns/1ps
`default_nettype none

module z80_mem_port (
   input  wire logic                                GPU_CLK,
   input  wire logic                                arst_n,
   input  wire logic [z80_bus_pkg::ADDR_W-1:0]      addr_q,
   input  wire logic [z80_bus_pkg::DATA_W-1:0]      wdata_q,
   input  wire logic                                rd_active,
   input  wire logic                                rd_start,
   input  wire logic                                wr_start,
   input  wire logic [z80_bus_pkg::DATA_W-1:0]      gpu_rdata,
   input  wire logic                                gpu_rd_rdy,
   output logic      [z80_bus_pkg::GPU_ADDR_W-1:0]  gpu_addr,
   output logic      [z80_bus_pkg::DATA_W-1:0]      gpu_wdata,
   output logic                                     gpu_wr_ena,
   output logic                                     gpu_rd_req,
   output logic      [z80_bus_pkg::DATA_W-1:0]      mem_rdata,
   output logic                                     mem_rvalid
);

   logic in_bank, in_range, in_id;
   logic rd_pend;                                 // RAM read issued, data not back yet

   // ********************
   // Window decode
   // ********************
   assign in_bank  = (addr_q[21:19] == gpu_map_pkg::MEM_BANK);
   assign in_range = in_bank && ({1'b0, addr_q[18:0]} < gpu_map_pkg::MEM_SIZE_BYTES);
   assign in_id    = in_bank && (addr_q[18:4] == gpu_map_pkg::BANK_ID_ADDR);

   always_ff @(posedge GPU_CLK or negedge arst_n) begin
      if (!arst_n) begin
         gpu_wr_ena <= 1'b0;
         gpu_rd_req <= 1'b0;
         rd_pend    <= 1'b0;
         mem_rvalid <= 1'b0;
      end else begin
         gpu_wr_ena <= wr_start && in_range;      // One cycle each
         gpu_rd_req <= rd_start && in_range;
         if (!rd_active) begin                    // Read over, drop the byte
            rd_pend    <= 1'b0;
            mem_rvalid <= 1'b0;
         end else if (rd_start && in_range) begin
            rd_pend <= 1'b1;
         end else if (rd_pend && gpu_rd_rdy) begin
            rd_pend    <= 1'b0;
            mem_rvalid <= 1'b1;
         end else if (in_bank && !in_range) begin
            mem_rvalid <= 1'b1;                   // Answered locally
         end
      end
   end

   always_ff @(posedge GPU_CLK) begin
      if ((rd_start || wr_start) && in_range) gpu_addr <= addr_q[z80_bus_pkg::GPU_ADDR_W-1:0];
      if (wr_start) gpu_wdata <= wdata_q;
      if (rd_pend && gpu_rd_rdy)              mem_rdata <= gpu_rdata;
      else if (gpu_map_pkg::BANK_RESPONSE && in_id) mem_rdata <= gpu_map_pkg::BANK_ID[addr_q[3:0]];
      else if (in_bank && !in_range)          mem_rdata <= 8'hFF; // Unpopulated bank space
   end

endmodule

`default_nettype wire

// File: src/z80_io_port.sv
`timescale 1ns/1ps
`default_nettype none

module z80_io_port (
   input  wire logic                             GPU_CLK,
   input  wire logic                             arst_n,
   input  wire logic [z80_bus_pkg::ADDR_W-1:0]   addr_q,
   input  wire logic [z80_bus_pkg::DATA_W-1:0]   wdata_q,
   input  wire logic                             rd_active,
   input  wire logic                             rd_start,
   input  wire logic                             wr_start,
   input  wire logic [7:0]                       ps2_char,
   input  wire logic [7:0]                       ps2_stat,
   input  wire logic [7:0]                       geo_stat_rd,
   output logic                                  spkr_en,
   output logic      [8:0]                       snd_data,
   output logic                                  snd_data_tx,
   output logic      [7:0]                       geo_wr_lo,
   output logic                                  geo_wr_lo_strobe,
   output logic      [7:0]                       geo_wr_hi,
   output logic                                  geo_wr_hi_strobe,
   output logic                                  kbd_read_data,
   output logic      [z80_bus_pkg::DATA_W-1:0]   io_rdata,
   output logic                                  io_rvalid
);

   gpu_map_pkg::io_port_e port;                   // Low address byte
   logic                  in_range;
   logic                  snd_wr;

   assign port     = gpu_map_pkg::io_port_e'(addr_q[7:0]);
   assign in_range = (addr_q[7:0] >= gpu_map_pkg::PORT_FIRST) &&
                     (addr_q[7:0] <= gpu_map_pkg::PORT_LAST);
   assign snd_wr   = wr_start && (port == gpu_map_pkg::snd_ton || port == gpu_map_pkg::snd_dur);
   assign kbd_read_data = rd_start && (port == gpu_map_pkg::io_data); // Clears the latch

   // ********************
   // Write strobes
   // ********************
   always_ff @(posedge GPU_CLK or negedge arst_n) begin
      if (!arst_n) begin
         {spkr_en, snd_data_tx, geo_wr_lo_strobe, geo_wr_hi_strobe} <= '0;
         io_rvalid <= 1'b0;
      end else begin
         spkr_en          <= wr_start && (port == gpu_map_pkg::snd_out);
         snd_data_tx      <= snd_wr;
         geo_wr_lo_strobe <= wr_start && (port == gpu_map_pkg::geo_lo);
         geo_wr_hi_strobe <= wr_start && (port == gpu_map_pkg::geo_hi);
         if (!rd_active)                 io_rvalid <= 1'b0;
         else if (rd_start && in_range)  io_rvalid <= 1'b1;   // Held to end of read
      end
   end

   always_ff @(posedge GPU_CLK) begin
      if (snd_wr) snd_data <= {port == gpu_map_pkg::snd_ton, wdata_q}; // Bit 8 picks tone
      if (wr_start && port == gpu_map_pkg::geo_lo) geo_wr_lo <= wdata_q;
      if (wr_start && port == gpu_map_pkg::geo_hi) geo_wr_hi <= wdata_q;
      if (rd_start) begin
         case (port)
            gpu_map_pkg::io_data:   io_rdata <= ps2_char;
            gpu_map_pkg::io_stat:   io_rdata <= ps2_stat;
            gpu_map_pkg::fifo_stat: io_rdata <= geo_stat_rd;
            default:                io_rdata <= 8'hFF;   // Write-only ports
         endcase
      end
   end

endmodule

`default_nettype wire

// File: src/ps2_key_latch.sv
`timescale 1ns/1ps
`default_nettype none

module ps2_key_latch (
   input  wire logic       GPU_CLK,
   input  wire logic       arst_n,
   input  wire logic       ps2_rdy,
   input  wire logic [7:0] ps2_dat,
   input  wire logic [7:0] ps2_status,
   input  wire logic       kbd_read_data,
   output logic      [7:0] ps2_char,
   output logic      [7:0] ps2_stat
);

   logic [7:0] rdy_hist;                          // Newest sample in bit 0
   logic       key_ready;

   assign key_ready = (rdy_hist == gpu_map_pkg::PS2_RDY_PATTERN);

   // Status: bit 0 ready, bit 1 break, bits 4..2 keyboard flags
   always_ff @(posedge GPU_CLK or negedge arst_n) begin
      if (!arst_n) begin
         rdy_hist <= '0;
         ps2_char <= '0;
         ps2_stat <= '0;
      end else begin
         rdy_hist <= {rdy_hist[6:0], ps2_rdy};
         if (key_ready) begin                     // New key wins over a read
            ps2_char <= ps2_dat;
            ps2_stat <= {3'b000, ps2_status[2:0], ps2_dat[7], 1'b1};
         end else if (kbd_read_data) begin
            ps2_char    <= '0;                    // Character consumed
            ps2_stat[0] <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

// File: src/z80_read_return.sv
`timescale 1ns/1ps
`default_nettype none

module z80_read_return (
   input  wire logic                             GPU_CLK,
   input  wire logic                             arst_n,
   input  wire logic                             rd_n_q,
   input  wire logic [z80_bus_pkg::DATA_W-1:0]   mem_rdata,
   input  wire logic                             mem_rvalid,
   input  wire logic [z80_bus_pkg::DATA_W-1:0]   io_rdata,
   input  wire logic                             io_rvalid,
   output logic      [z80_bus_pkg::DATA_W-1:0]   rdata,
   output logic                                  rdata_ena,
   output logic                                  data_dir
);

   logic [z80_bus_pkg::DATA_W-1:0] drv_data, drv_data_r; // Drive register, retime stage
   logic                           drv_ena,  drv_ena_r;
   logic                           drv_dir,  drv_dir_r;

   always_ff @(posedge GPU_CLK or negedge arst_n) begin
      if (!arst_n) begin
         {drv_ena, drv_ena_r, rdata_ena} <= '0;
         {drv_dir, drv_dir_r, data_dir}  <= {3{z80_bus_pkg::DIR_IN}};
      end else begin
         if (rd_n_q) begin                        // Z80 done reading, release bus
            drv_ena <= 1'b0;
            drv_dir <= z80_bus_pkg::DIR_IN;
         end else if (mem_rvalid || io_rvalid) begin
            drv_ena <= 1'b1;
            drv_dir <= z80_bus_pkg::DIR_OUT;
         end
         drv_ena_r <= drv_ena;                    // Two stages toward slow Z80 pins
         rdata_ena <= drv_ena_r;
         drv_dir_r <= drv_dir;
         data_dir  <= drv_dir_r;
      end
   end

   // ********************
   // Data path
   // ********************
   always_ff @(posedge GPU_CLK) begin
      if (!rd_n_q && mem_rvalid)     drv_data <= mem_rdata;
      else if (!rd_n_q && io_rvalid) drv_data <= io_rdata;
      drv_data_r <= drv_data;
      rdata      <= drv_data_r;
   end

endmodule

`default_nettype wire

// File: src/z80_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module z80_bridge (
   input  wire logic                                GPU_CLK,
   input  wire logic                                arst_n,
   input  wire logic                                z80_clk,
   input  wire logic                                m1_n,
   input  wire logic                                mreq_n,
   input  wire logic                                iorq_n,
   input  wire logic                                rd_n,
   input  wire logic                                wr_n,
   input  wire logic [z80_bus_pkg::ADDR_W-1:0]      z80_addr,
   input  wire logic [z80_bus_pkg::DATA_W-1:0]      z80_wdata,
   input  wire logic [z80_bus_pkg::DATA_W-1:0]      gpu_rdata,
   input  wire logic                                gpu_rd_rdy,
   input  wire logic                                ps2_rdy,
   input  wire logic [7:0]                          ps2_dat,
   input  wire logic [7:0]                          ps2_status,
   input  wire logic [7:0]                          geo_stat_rd,
   output logic      [z80_bus_pkg::GPU_ADDR_W-1:0]  gpu_addr,
   output logic      [z80_bus_pkg::DATA_W-1:0]      gpu_wdata,
   output logic                                     gpu_wr_ena,
   output logic                                     gpu_rd_req,
   output logic                                     spkr_en,
   output logic      [8:0]                          snd_data,
   output logic                                     snd_data_tx,
   output logic      [7:0]                          geo_wr_lo,
   output logic                                     geo_wr_lo_strobe,
   output logic      [7:0]                          geo_wr_hi,
   output logic                                     geo_wr_hi_strobe,
   output logic      [z80_bus_pkg::DATA_W-1:0]      rdata,
   output logic                                     rdata_ena,
   output logic                                     data_dir
);

   logic [z80_bus_pkg::ADDR_W-1:0] addr_q;
   logic [z80_bus_pkg::DATA_W-1:0] wdata_q, mem_rdata, io_rdata;
   logic                           rd_n_q, wr_n_q, zclk;
   logic raw_mem_read, raw_mem_write, raw_port_read, raw_port_write;
   logic mem_rd_active, mem_rd_start, mem_wr_start;   // Memory filter results
   logic port_rd_active, port_rd_start, port_wr_start; // Port filter results
   logic mem_rvalid, io_rvalid, kbd_read_data;
   logic [7:0] ps2_char, ps2_stat;

   z80_bus_sampler u_sampler (.*);

   // ********************
   // Cycle filters
   // ********************
   z80_cycle_filter #(.FILTER_LEN(z80_bus_pkg::MEM_FILTER)) u_mem_rd_filter (
      .GPU_CLK, .arst_n, .zclk, .raw(raw_mem_read), .strobe_n(rd_n_q),
      .active(mem_rd_active), .start(mem_rd_start));
   z80_cycle_filter #(.FILTER_LEN(z80_bus_pkg::MEM_FILTER)) u_mem_wr_filter (
      .GPU_CLK, .arst_n, .zclk, .raw(raw_mem_write), .strobe_n(wr_n_q),
      .active(), .start(mem_wr_start));             // Writes act on the start only
   z80_cycle_filter #(.FILTER_LEN(z80_bus_pkg::PORT_FILTER)) u_port_rd_filter (
      .GPU_CLK, .arst_n, .zclk, .raw(raw_port_read), .strobe_n(rd_n_q),
      .active(port_rd_active), .start(port_rd_start));
   z80_cycle_filter #(.FILTER_LEN(z80_bus_pkg::PORT_FILTER)) u_port_wr_filter (
      .GPU_CLK, .arst_n, .zclk, .raw(raw_port_write), .strobe_n(wr_n_q),
      .active(), .start(port_wr_start));

   z80_mem_port u_mem_port (
      .GPU_CLK, .arst_n, .addr_q, .wdata_q, .rd_active(mem_rd_active),
      .rd_start(mem_rd_start), .wr_start(mem_wr_start), .gpu_rdata, .gpu_rd_rdy,
      .gpu_addr, .gpu_wdata, .gpu_wr_ena, .gpu_rd_req, .mem_rdata, .mem_rvalid);

   z80_io_port u_io_port (
      .GPU_CLK, .arst_n, .addr_q, .wdata_q, .rd_active(port_rd_active),
      .rd_start(port_rd_start), .wr_start(port_wr_start), .ps2_char, .ps2_stat,
      .geo_stat_rd, .spkr_en, .snd_data, .snd_data_tx, .geo_wr_lo, .geo_wr_lo_strobe,
      .geo_wr_hi, .geo_wr_hi_strobe, .kbd_read_data, .io_rdata, .io_rvalid);

   ps2_key_latch u_key_latch (.*);

   z80_read_return u_read_return (.*);             // Both sources share one drive path

endmodule

`default_nettype wire

// File: sim/z80_bridge_assert.sv
`timescale 1ns/1ps
`default_nettype none

module z80_bridge_assert (
   input wire logic GPU_CLK,
   input wire logic arst_n,
   input wire logic gpu_wr_ena,
   input wire logic geo_wr_lo_strobe,
   input wire logic geo_wr_hi_strobe,
   input wire logic rd_n,
   input wire logic rdata_ena
);

   // ********************
   // Strobe width
   // ********************
   wr_one_cycle: assert property (@(posedge GPU_CLK) disable iff (!arst_n)
      gpu_wr_ena |=> !gpu_wr_ena)
      else $error("gpu_wr_ena longer than one cycle");

   geo_lo_one_cycle: assert property (@(posedge GPU_CLK) disable iff (!arst_n)
      geo_wr_lo_strobe |=> !geo_wr_lo_strobe)
      else $error("geo_wr_lo_strobe longer than one cycle");

   geo_hi_one_cycle: assert property (@(posedge GPU_CLK) disable iff (!arst_n)
      geo_wr_hi_strobe |=> !geo_wr_hi_strobe)
      else $error("geo_wr_hi_strobe longer than one cycle");

   // Bus released by 4 cycles after rd_n has stayed high 4 cycles
   bus_release: assert property (@(posedge GPU_CLK) disable iff (!arst_n)
      (rd_n && $past(rd_n, 1) && $past(rd_n, 2) && $past(rd_n, 3) && $past(rd_n, 4)
       && $past(rd_n, 5) && $past(rd_n, 6) && $past(rd_n, 7)) |-> !rdata_ena)
      else $error("rdata_ena still high after read strobe release");

endmodule

`default_nettype wire

// File: sim/tb_z80_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module tb_z80_bridge;

   logic        GPU_CLK, arst_n, z80_clk;
   logic        m1_n, mreq_n, iorq_n, rd_n, wr_n;
   logic [21:0] z80_addr;
   logic [7:0]  z80_wdata, gpu_rdata, ps2_dat, ps2_status, geo_stat_rd;
   logic        gpu_rd_rdy, ps2_rdy;
   logic [19:0] gpu_addr;
   logic [7:0]  gpu_wdata, geo_wr_lo, geo_wr_hi, rdata;
   logic [8:0]  snd_data;
   logic        gpu_wr_ena, gpu_rd_req, spkr_en, snd_data_tx;
   logic        geo_wr_lo_strobe, geo_wr_hi_strobe, rdata_ena, data_dir;

   logic [47:0] lines [64];                       // kind, address, data, expected
   int          n_lines = 0;
   int          err_cnt = 0;
   logic [15:0] lfsr = 16'd39294;
   logic [7:0]  model_data;                       // Byte the GPU RAM model returns

   z80_bridge u_z80_bridge (.*);

   bind z80_bridge z80_bridge_assert u_bridge_assert (.*);

   initial begin
      GPU_CLK = 1'b0;
      forever #2 GPU_CLK = ~GPU_CLK;             // 4 ns period
   end

   initial begin
      z80_clk = 1'b0;
      forever begin
         repeat (4) @(negedge GPU_CLK);           // Divide by 8
         z80_clk = ~z80_clk;
      end
   end

   // Galois LFSR with taps 16,14,13,11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   task automatic check(input logic ok, input string what);
      assert (ok) else begin
         err_cnt++;
         $display("FAIL %0t: %s", $time, what);
         $display("Done: errors found");
         $fatal(1, "Stopped at first error");
      end
   endtask

   // ********************
   // GPU RAM model
   // ********************
   initial begin : gpu_model
      logic [2:0] d;
      forever begin
         @(negedge GPU_CLK);
         if (gpu_rd_req) begin
            for (int b = 0; b < 3; b++) begin     // One step per bit taken
               d    = {d[1:0], lfsr[0]};
               lfsr = lfsr_next(lfsr);
            end
            repeat (int'(d) + 1) @(negedge GPU_CLK);
            gpu_rdata  = model_data;
            gpu_rd_rdy = 1'b1;
            @(negedge GPU_CLK);
            gpu_rd_rdy = 1'b0;
         end
      end
   end

   initial begin : watchdog
      wait (n_lines > 0);
      repeat (n_lines * 200) @(posedge GPU_CLK);
      $display("Watchdog expired before the test sequence finished");
      $display("Done: errors found");
      $fatal(1, "Timeout");
   end

   task automatic key_press(input logic [7:0] ch, input logic [7:0] st);
      @(negedge GPU_CLK);
      ps2_dat    = ch;
      ps2_status = st;
      repeat (8) @(negedge GPU_CLK);              // Low half of the ready pattern
      ps2_rdy = 1'b1;
      repeat (8) @(negedge GPU_CLK);
      ps2_rdy = 1'b0;
   endtask

   task automatic run_line(input logic [47:0] w);
      logic [3:0]  kind;
      logic [21:0] addr;
      logic [7:0]  data;
      logic [11:0] exp_v;
      logic [7:0]  got;
      int          n_wr, n_req, n_snd, n_lo, n_hi, n_spk;
      bit          ena_seen, is_rd;
      kind  = w[47:44];
      addr  = w[41:20];
      data  = w[19:12];
      exp_v = w[11:0];
      {n_wr, n_req, n_snd, n_lo, n_hi, n_spk} = '0;
      ena_seen = 1'b0;
      got      = '0;
      is_rd    = (kind == 2 || kind == 3 || kind == 5);
      @(negedge GPU_CLK);
      z80_addr    = addr;
      z80_wdata   = data;
      model_data  = data;
      geo_stat_rd = data;
      mreq_n      = (kind > 3);
      iorq_n      = (kind <= 3);
      rd_n        = !is_rd;
      wr_n        = is_rd;
      for (int i = 0; i < 56; i++) begin          // 6 Z80 clocks of strobe then release
         @(negedge GPU_CLK);
         if (i == 48) {mreq_n, iorq_n, rd_n, wr_n} = '1;
         n_wr  += gpu_wr_ena;
         n_req += gpu_rd_req;
         n_snd += snd_data_tx;
         n_lo  += geo_wr_lo_strobe;
         n_hi  += geo_wr_hi_strobe;
         n_spk += spkr_en;
         if (rdata_ena && !ena_seen) begin        // First cycle on the pins
            ena_seen = 1'b1;
            got      = rdata;
            check(data_dir == z80_bus_pkg::DIR_OUT, "data_dir not DIR_OUT while driving");
         end
      end
      if (kind == 0) begin
         check(n_wr == 1, $sformatf("expected one gpu_wr_ena, saw %0d", n_wr));
         check(gpu_addr == addr[19:0] && gpu_wdata == exp_v[7:0],
               $sformatf("write addr %h data %h", gpu_addr, gpu_wdata));
      end else if (kind == 1) begin
         check(n_wr == 0, $sformatf("write outside RAM gave %0d gpu_wr_ena", n_wr));
      end else if (kind == 4) begin
         case (addr[7:0])
            8'hF4, 8'hF5: check(n_snd == 1 && snd_data == exp_v[8:0],
                                $sformatf("snd_data %h pulses %0d", snd_data, n_snd));
            8'hF6:        check(n_lo == 1 && geo_wr_lo == exp_v[7:0],
                                $sformatf("geo_wr_lo %h pulses %0d", geo_wr_lo, n_lo));
            8'hF7:        check(n_hi == 1 && geo_wr_hi == exp_v[7:0],
                                $sformatf("geo_wr_hi %h pulses %0d", geo_wr_hi, n_hi));
            default:      check(n_spk == 1, $sformatf("spkr_en pulses %0d", n_spk));
         endcase
      end
      if (is_rd) begin
         check(ena_seen, "read data was never driven to the Z80");
         check(got == exp_v[7:0], $sformatf("rdata %h expected %h", got, exp_v[7:0]));
         check(n_req == ((kind == 2) ? 1 : 0), $sformatf("gpu_rd_req pulses %0d", n_req));
         check(!rdata_ena && data_dir == z80_bus_pkg::DIR_IN, "bus not released after read");
      end
      repeat (16) @(negedge GPU_CLK);             // Idle gap lets the filters clear
   endtask

   // ********************
   // Main sequence
   // ********************
   initial begin
      arst_n = 1'b0;
      {m1_n, mreq_n, iorq_n, rd_n, wr_n} = '1;
      z80_addr   = '0;
      z80_wdata  = '0;
      gpu_rdata  = '0;
      gpu_rd_rdy = 1'b0;
      ps2_rdy    = 1'b0;
      ps2_dat    = '0;
      ps2_status = '0;
      geo_stat_rd = '0;
      model_data = '0;
      for (int i = 0; i < 64; i++) lines[i] = {4'hF, 44'h0};
      $readmemh("sim/z80_bridge_input.txt", lines);
      while (n_lines < 64 && lines[n_lines][47:44] != 4'hF) n_lines++;
      check(n_lines > 0, "no transactions found in sim/z80_bridge_input.txt");
      repeat (8) @(negedge GPU_CLK);
      arst_n = 1'b1;
      repeat (8) @(negedge GPU_CLK);
      for (int i = 0; i < n_lines; i++) begin
         if (lines[i][47:44] == 4'h6) key_press(lines[i][19:12], lines[i][27:20]);
         else                          run_line(lines[i]);
      end
      if (err_cnt == 0) begin
         $display("Done: no errors");
         $finish;
      end else begin
         $display("Done: errors found");
         $fatal(1, "Checks failed");
      end
   end

endmodule

`default_nettype wire

// File: sim/z80_bridge_input.txt
// kind(1) addr(6) data(2) expected(3), hex; kind 0 wr ok, 1 wr none, 2 RAM rd,
// 3 local rd, 4 port wr, 5 port rd, 6 PS/2 key (addr = status), F end
01001233C03C
110A00055000
100012377000
2100456A50A5
3110000000FF
317FFF500020
40000F481181
40000F512012
40000F6C30C3
40000F70D00D
40000F201001
60000059C000
50000F100017
50000F00009C
50000F100016
50000F000000
50000F85A05A
F00000000000

// File: filelist.f
src/z80_bus_pkg.sv
src/gpu_map_pkg.sv
src/z80_bus_sampler.sv
src/z80_cycle_filter.sv
src/z80_mem_port.sv
src/z80_io_port.sv
src/ps2_key_latch.sv
src/z80_read_return.sv
src/z80_bridge.sv
sim/z80_bridge_assert.sv
sim/tb_z80_bridge.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_z80_bridge
FILELIST  = filelist.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "Done: no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
